// ==== Makefile ====
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert
TOP      ?= tb_riscv_core
FILELIST ?= project.f

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== hw/riscv_alu.sv ====
////////////////////////////////////////
// Combinational ALU, shifts use operand b 4:0
////////////////////////////////////////

`timescale 1ns/1ps

module riscv_alu
  import riscv_pkg::*;
(
  input  alu_op_e operator_i,
  input  word_t   operand_a_i,
  input  word_t   operand_b_i,
  output word_t   result_o,
  output logic    eq_o         // Branch compare
);

  logic [4:0] shamt;
  logic       lt_signed;

  assign shamt     = operand_b_i[4:0];
  assign lt_signed = $signed(operand_a_i) < $signed(operand_b_i);

  always_comb begin
    case (operator_i)
      ALU_ADD: result_o = operand_a_i + operand_b_i; // Also load/store address
      ALU_SUB: result_o = operand_a_i - operand_b_i;
      ALU_AND: result_o = operand_a_i & operand_b_i;
      ALU_OR:  result_o = operand_a_i | operand_b_i;
      ALU_XOR: result_o = operand_a_i ^ operand_b_i;
      ALU_SLT: result_o = {{(XLEN-1){1'b0}}, lt_signed};
      ALU_SLL: result_o = operand_a_i << shamt;
      ALU_SRL: result_o = operand_a_i >> shamt;   // Logical
      default: result_o = '0;
    endcase
  end

  // Independent of operator
  assign eq_o = (operand_a_i == operand_b_i);

endmodule

// ==== hw/riscv_controller.sv ====
////////////////////////////////////////
// Multicycle FSM, decode and writeback select
// Unknown opcodes and unsupported funct codes retire as NOP
////////////////////////////////////////

`timescale 1ns/1ps

module riscv_controller
  import riscv_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n_i,
  input  logic    fetch_enable_i,
  output logic    core_busy_o,
  fetch_if.ctrl   fetch,
  rf_if.ctrl      rf,
  lsu_if.ctrl     lsu,
  output alu_op_e alu_operator_o,
  output word_t   alu_operand_a_o,
  output word_t   alu_operand_b_o,
  input  word_t   alu_result_i,
  input  logic    alu_eq_i
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  opcode_e opcode;
  logic [2:0] funct3;
  logic       funct7_b5; // SUB select
  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_u;

  logic is_lui, is_op, is_op_imm, is_load, is_store, is_branch;
  logic    op_ok;    // funct3 is in the kept set
  alu_op_e alu_op;
  logic    taken;
  logic    complete; // Instruction finishes this cycle

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////
  assign opcode    = opcode_e'(fetch.instr[6:0]);
  assign funct3    = fetch.instr[14:12];
  assign funct7_b5 = fetch.instr[30];

  assign imm_i = {{20{fetch.instr[31]}}, fetch.instr[31:20]};
  assign imm_s = {{20{fetch.instr[31]}}, fetch.instr[31:25], fetch.instr[11:7]};
  assign imm_b = {{19{fetch.instr[31]}}, fetch.instr[31], fetch.instr[7],
                  fetch.instr[30:25], fetch.instr[11:8], 1'b0};
  assign imm_u = {fetch.instr[31:12], 12'b0};

  assign is_lui    = (opcode == OPC_LUI);
  assign is_op     = (opcode == OPC_OP);
  assign is_op_imm = (opcode == OPC_OP_IMM);
  assign is_load   = (opcode == OPC_LOAD);
  assign is_store  = (opcode == OPC_STORE);
  assign is_branch = (opcode == OPC_BRANCH);

  // ALU operator from funct3, shared by OP and OP-IMM
  always_comb begin
    alu_op = ALU_ADD;
    op_ok  = 1'b1;
    case (funct3)
      3'b000: alu_op = (is_op && funct7_b5) ? ALU_SUB : ALU_ADD;
      3'b111: alu_op = ALU_AND;
      3'b110: alu_op = ALU_OR;
      3'b100: alu_op = ALU_XOR;
      3'b010: alu_op = ALU_SLT;
      3'b001: begin
        alu_op = ALU_SLL;
        op_ok  = is_op;            // No SLLI
      end
      3'b101: begin
        alu_op = ALU_SRL;
        op_ok  = is_op && !funct7_b5; // No SRA, no SRLI
      end
      default: op_ok = 1'b0;       // SLTU and friends
    endcase
  end

  assign alu_operator_o  = (is_op || is_op_imm) ? alu_op :
                           is_branch ? ALU_SUB : ALU_ADD; // Addresses use ADD
  assign alu_operand_a_o = rf.rdata_a;
  assign alu_operand_b_o = (is_op || is_branch) ? rf.rdata_b :
                           is_store ? imm_s : imm_i;

  // BEQ and BNE only
  assign taken = is_branch && ((funct3 == 3'b000 && alu_eq_i) ||
                               (funct3 == 3'b001 && !alu_eq_i));

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////
  assign complete = (state_q == ST_EXECUTE && !(is_load || is_store)) ||
                    (state_q == ST_MEM && lsu.done);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:    if (fetch_enable_i) state_d = ST_FETCH;
      ST_FETCH:   if (fetch.instr_valid) state_d = ST_EXECUTE;
      ST_EXECUTE: begin
        if (is_load || is_store) state_d = ST_MEM;
        else state_d = fetch_enable_i ? ST_FETCH : ST_IDLE;
      end
      ST_MEM:     if (lsu.done) state_d = fetch_enable_i ? ST_FETCH : ST_IDLE;
      default:    state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) state_q <= ST_IDLE;
    else state_q <= state_d;
  end

  assign core_busy_o = (state_q != ST_IDLE);

  // Fetch and PC update
  assign fetch.fetch_req     = fetch_enable_i && (state_q == ST_IDLE || complete);
  assign fetch.retire        = complete;
  assign fetch.pc_set        = (state_q == ST_EXECUTE) && taken;
  assign fetch.branch_offset = imm_b;

  // Register file
  assign rf.raddr_a = fetch.instr[19:15];
  assign rf.raddr_b = fetch.instr[24:20];
  assign rf.waddr   = fetch.instr[11:7];
  assign rf.we      = (state_q == ST_EXECUTE && (is_lui || ((is_op || is_op_imm) && op_ok))) ||
                      (state_q == ST_MEM && lsu.done && is_load);
  assign rf.wdata   = is_lui ? imm_u : is_load ? lsu.rdata : alu_result_i;

  // Data memory
  assign lsu.req   = (state_q == ST_EXECUTE) && (is_load || is_store);
  assign lsu.we    = is_store;
  assign lsu.addr  = alu_result_i;
  assign lsu.wdata = rf.rdata_b;

  a_state_legal: assert property (@(posedge clk) disable iff (!rst_n_i)
    state_q inside {ST_IDLE, ST_FETCH, ST_EXECUTE, ST_MEM});

  a_write_window: assert property (@(posedge clk) disable iff (!rst_n_i)
    rf.we |-> state_q == ST_EXECUTE || (state_q == ST_MEM && lsu.done && is_load));

  // PC only moves on retire, checked across the fetch unit
  a_pc_steady: assert property (@(posedge clk) disable iff (!rst_n_i)
    state_q != ST_IDLE && !fetch.retire |=> $stable(fetch.pc));

endmodule

// ==== hw/riscv_core.sv ====
////////////////////////////////////////
// Multicycle RV32I subset core top level
// boot_addr_i is sampled only during reset
////////////////////////////////////////

`timescale 1ns/1ps

module riscv_core
  import riscv_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n_i,
  input  word_t boot_addr_i,
  input  logic  fetch_enable_i,
  output logic  core_busy_o,
  // Instruction memory
  output logic  instr_req_o,
  input  logic  instr_gnt_i,
  input  logic  instr_rvalid_i,
  output word_t instr_addr_o,
  input  word_t instr_rdata_i,
  // Data memory
  output logic  data_req_o,
  input  logic  data_gnt_i,
  input  logic  data_rvalid_i,
  output logic  data_we_o,
  output word_t data_addr_o,
  output word_t data_wdata_o,
  input  word_t data_rdata_i
);

  fetch_if fetch_bus ();
  rf_if    rf_bus ();
  lsu_if   lsu_bus ();

  alu_op_e alu_operator;
  word_t   alu_operand_a;
  word_t   alu_operand_b;
  word_t   alu_result;
  logic    alu_eq;

  ////////////////////////////////////////
  // Fetch and control
  ////////////////////////////////////////
  riscv_if_unit if_unit_i (
    .clk            ( clk            ),
    .rst_n_i        ( rst_n_i        ),
    .boot_addr_i    ( boot_addr_i    ),
    .fetch          ( fetch_bus      ),
    .instr_req_o    ( instr_req_o    ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_rdata_i  ( instr_rdata_i  )
  );

  riscv_controller controller_i (
    .clk             ( clk            ),
    .rst_n_i         ( rst_n_i        ),
    .fetch_enable_i  ( fetch_enable_i ),
    .core_busy_o     ( core_busy_o    ),
    .fetch           ( fetch_bus      ),
    .rf              ( rf_bus         ),
    .lsu             ( lsu_bus        ),
    .alu_operator_o  ( alu_operator   ),
    .alu_operand_a_o ( alu_operand_a  ),
    .alu_operand_b_o ( alu_operand_b  ),
    .alu_result_i    ( alu_result     ),
    .alu_eq_i        ( alu_eq         )
  );

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////
  riscv_alu alu_i (
    .operator_i  ( alu_operator  ),
    .operand_a_i ( alu_operand_a ),
    .operand_b_i ( alu_operand_b ),
    .result_o    ( alu_result    ),
    .eq_o        ( alu_eq        )
  );

  riscv_register_file registers_i (
    .clk     ( clk     ),
    .rst_n_i ( rst_n_i ),
    .rf      ( rf_bus  )
  );

  riscv_load_store_unit load_store_unit_i (
    .clk           ( clk           ),
    .rst_n_i       ( rst_n_i       ),
    .lsu           ( lsu_bus       ),
    .data_req_o    ( data_req_o    ),
    .data_gnt_i    ( data_gnt_i    ),
    .data_rvalid_i ( data_rvalid_i ),
    .data_we_o     ( data_we_o     ),
    .data_addr_o   ( data_addr_o   ),
    .data_wdata_o  ( data_wdata_o  ),
    .data_rdata_i  ( data_rdata_i  )
  );

endmodule

// ==== hw/riscv_if_unit.sv ====
////////////////////////////////////////
// PC and instruction fetch, one fetch in flight
// PC loads boot_addr_i during reset
////////////////////////////////////////

`timescale 1ns/1ps

module riscv_if_unit
  import riscv_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n_i,
  input  word_t  boot_addr_i,
  fetch_if.fetch fetch,
  output logic   instr_req_o,
  input  logic   instr_gnt_i,
  input  logic   instr_rvalid_i,
  output word_t  instr_addr_o,
  input  word_t  instr_rdata_i
);

  word_t pc_q;    // Current PC
  word_t instr_q; // Instruction hold register
  logic  req_q;   // Request waiting for grant
  logic  wait_q;  // Granted, waiting for rvalid
  logic  valid_q;

  // Control state and PC
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      pc_q    <= boot_addr_i;
      req_q   <= 1'b0;
      wait_q  <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      if (fetch.pc_set) begin
        pc_q <= pc_q + fetch.branch_offset; // Branch wins over retire
      end else if (fetch.retire) begin
        pc_q <= pc_q + WORD_BYTES;
      end
      if (fetch.fetch_req) begin
        req_q <= 1'b1;
      end else if (req_q && instr_gnt_i) begin
        req_q  <= 1'b0;
        wait_q <= 1'b1;
      end
      if (wait_q && instr_rvalid_i) begin
        wait_q  <= 1'b0;
        valid_q <= 1'b1; // Pulse together with held word
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wait_q && instr_rvalid_i) instr_q <= instr_rdata_i;
  end

  assign instr_req_o       = req_q;
  assign instr_addr_o      = pc_q;  // PC only moves at retire
  assign fetch.pc          = pc_q;
  assign fetch.instr       = instr_q;
  assign fetch.instr_valid = valid_q;

  // Request held steady until granted
  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o));

endmodule

// ==== hw/riscv_intf.sv ====
////////////////////////////////////////
// Internal buses between controller and units
// All pulses are one cycle wide
////////////////////////////////////////

`timescale 1ns/1ps

////////////////////////////////////////
// Controller <-> fetch unit
////////////////////////////////////////
interface fetch_if import riscv_pkg::*; ();
  logic  fetch_req;     // Start one fetch
  logic  instr_valid;   // Fetched word ready
  word_t instr;         // Held until next fetch
  word_t pc;            // Address of held instruction
  logic  pc_set;        // Taken branch
  word_t branch_offset; // B immediate
  logic  retire;        // Instruction done

  modport ctrl (
    output fetch_req, pc_set, branch_offset, retire,
    input  instr_valid, instr, pc
  );
  modport fetch (
    input  fetch_req, pc_set, branch_offset, retire,
    output instr_valid, instr, pc
  );
endinterface

////////////////////////////////////////
// Controller <-> register file
////////////////////////////////////////
interface rf_if import riscv_pkg::*; ();
  reg_addr_t raddr_a;
  reg_addr_t raddr_b;
  word_t     rdata_a; // Combinational read
  word_t     rdata_b;
  reg_addr_t waddr;
  logic      we;
  word_t     wdata;

  modport ctrl (output raddr_a, raddr_b, waddr, we, wdata, input rdata_a, rdata_b);
  modport rf   (input raddr_a, raddr_b, waddr, we, wdata, output rdata_a, rdata_b);
endinterface

////////////////////////////////////////
// Controller <-> load store unit
////////////////////////////////////////
interface lsu_if import riscv_pkg::*; ();
  logic  req;   // One cycle, sampled by lsu
  logic  we;    // Store when high
  word_t addr;
  word_t wdata;
  word_t rdata; // Valid with done on loads
  logic  done;

  modport ctrl (output req, we, addr, wdata, input rdata, done);
  modport lsu  (input req, we, addr, wdata, output rdata, done);
endinterface

// ==== hw/riscv_load_store_unit.sv ====
////////////////////////////////////////
// Word loads and stores, one transaction in flight
// Address bits 1:0 are forced to zero
////////////////////////////////////////

`timescale 1ns/1ps

module riscv_load_store_unit
  import riscv_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n_i,
  lsu_if.lsu    lsu,
  output logic  data_req_o,
  input  logic  data_gnt_i,
  input  logic  data_rvalid_i,
  output logic  data_we_o,
  output word_t data_addr_o,
  output word_t data_wdata_o,
  input  word_t data_rdata_i
);

  logic  req_q;   // Waiting for grant
  logic  wait_q;  // Waiting for rvalid
  logic  we_q;
  logic  done_q;
  word_t addr_q;
  word_t wdata_q;
  word_t rdata_q; // Load data register

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      req_q  <= 1'b0;
      wait_q <= 1'b0;
      we_q   <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (lsu.req) begin
        req_q <= 1'b1;
        we_q  <= lsu.we;
      end else if (req_q && data_gnt_i) begin
        req_q  <= 1'b0;
        wait_q <= 1'b1;
      end
      if (wait_q && data_rvalid_i) begin
        wait_q <= 1'b0;
        done_q <= 1'b1;
      end
    end
  end

  // Payload, held from request to grant
  always_ff @(posedge clk) begin
    if (lsu.req) begin
      addr_q  <= {lsu.addr[XLEN-1:2], 2'b00};
      wdata_q <= lsu.wdata;
    end
    if (wait_q && data_rvalid_i) rdata_q <= data_rdata_i;
  end

  assign data_req_o   = req_q;
  assign data_we_o    = we_q;
  assign data_addr_o  = addr_q;
  assign data_wdata_o = wdata_q;
  assign lsu.done     = done_q;
  assign lsu.rdata    = rdata_q;

  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
    data_req_o && !data_gnt_i |=> data_req_o && $stable(data_addr_o) &&
                                  $stable(data_we_o) && $stable(data_wdata_o));

endmodule

// ==== hw/riscv_pkg.sv ====
////////////////////////////////////////
// Shared widths and encodings for the core
// RV32I subset only, all accesses are whole words
////////////////////////////////////////

package riscv_pkg;

  localparam int XLEN   = 32;
  localparam int N_REGS = 32;
  localparam int REG_AW = 5;

  typedef logic [XLEN-1:0]   word_t;     // Data and address word
  typedef logic [REG_AW-1:0] reg_addr_t; // Register index

  localparam word_t WORD_BYTES = 32'd4;  // Sequential PC step

  // Major opcodes, bits 6:0 of the instruction
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD = 4'd0,
    ALU_SUB = 4'd1,
    ALU_AND = 4'd2,
    ALU_OR  = 4'd3,
    ALU_XOR = 4'd4,
    ALU_SLT = 4'd5, // Signed compare
    ALU_SLL = 4'd6,
    ALU_SRL = 4'd7
  } alu_op_e;

  // One instruction at a time
  typedef enum logic [1:0] {
    ST_IDLE    = 2'd0,
    ST_FETCH   = 2'd1,
    ST_EXECUTE = 2'd2,
    ST_MEM     = 2'd3
  } ctrl_state_e;

endpackage

// ==== hw/riscv_register_file.sv ====
////////////////////////////////////////
// x1..x31 with reset, x0 hardwired to zero
////////////////////////////////////////

`timescale 1ns/1ps

module riscv_register_file
  import riscv_pkg::*;
(
  input logic clk,
  input logic rst_n_i,
  rf_if.rf    rf
);

  word_t regs [1:N_REGS-1]; // No storage for x0

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      for (int i = 1; i < N_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (rf.we && rf.waddr != '0) begin
      regs[rf.waddr] <= rf.wdata; // Writes to x0 dropped
    end
  end

  // Combinational reads
  assign rf.rdata_a = (rf.raddr_a == '0) ? '0 : regs[rf.raddr_a];
  assign rf.rdata_b = (rf.raddr_b == '0) ? '0 : regs[rf.raddr_b];

endmodule

// ==== project.f ====
hw/riscv_pkg.sv
hw/riscv_intf.sv
hw/riscv_if_unit.sv
hw/riscv_controller.sv
hw/riscv_alu.sv
hw/riscv_register_file.sv
hw/riscv_load_store_unit.sv
hw/riscv_core.sv
sim/tb_riscv_core.sv

// ==== sim/tb_riscv_core.sv ====
////////////////////////////////////////
// Random program testbench with memory models
// Loads and stores use x0 base, data image is 64 words
////////////////////////////////////////

`timescale 1ns/1ps

module tb_riscv_core
  import riscv_pkg::*;
();

  localparam word_t BOOT     = 32'h0000_0100;
  localparam int    N_INSTR  = 48;
  localparam word_t END_ADDR = BOOT + N_INSTR * 4; // End word location
  localparam word_t NOP      = 32'h0000_0013;     // ADDI x0, x0, 0

  logic  clk;
  logic  rst_n_i;
  word_t boot_addr_i;      // PC start, taken during reset
  logic  fetch_enable_i;
  logic  core_busy_o;
  logic  instr_req_o, instr_gnt_i, instr_rvalid_i;
  word_t instr_addr_o, instr_rdata_i;
  logic  data_req_o, data_gnt_i, data_rvalid_i, data_we_o;
  word_t data_addr_o, data_wdata_o, data_rdata_i;

  logic [31:0] lfsr_state;
  word_t prog [0:N_INSTR-1];
  word_t dmem [0:63];      // Memory seen by the DUT
  word_t model_mem [0:63]; // Memory of the reference model
  word_t pc_trace [$];
  word_t st_addr [$];
  word_t st_data [$];
  int    fetch_idx;
  int    st_idx;
  int    err [0:4];        // Per test error counts
  int    total;
  int    cnt;
  logic  aborted;

  riscv_core u_riscv_core (.*);

  always #50 clk = ~clk; // 100 ns period

  ////////////////////////////////////////
  // Random numbers and encoders
  ////////////////////////////////////////
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
      v = {v[30:0], lfsr_state[0]}; // One step per bit
    end
    return v;
  endfunction

  function automatic word_t enc_r(logic [6:0] f7, logic [31:0] rs2, logic [31:0] rs1,
                                  logic [2:0] f3, logic [31:0] rd, logic [6:0] opc);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], opc};
  endfunction

  function automatic word_t enc_i(logic [31:0] imm, logic [31:0] rs1, logic [2:0] f3,
                                  logic [31:0] rd, logic [6:0] opc);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
  endfunction

  function automatic word_t enc_s(logic [31:0] imm, logic [31:0] rs2);
    return {imm[11:5], rs2[4:0], 5'd0, 3'b010, imm[4:0], OPC_STORE}; // SW, base x0
  endfunction

  function automatic word_t enc_b(logic [31:0] imm, logic [31:0] rs2, logic [31:0] rs1,
                                  logic [2:0] f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  // Reference arithmetic straight from the ISA rules
  function automatic word_t alu_ref(logic [2:0] f3, logic sub, word_t a, word_t b);
    case (f3)
      3'b000:  return sub ? a - b : a + b;
      3'b111:  return a & b;
      3'b110:  return a | b;
      3'b100:  return a ^ b;
      3'b010:  return {31'd0, $signed(a) < $signed(b)};
      3'b001:  return a << b[4:0];
      3'b101:  return a >> b[4:0];
      default: return '0;
    endcase
  endfunction

  ////////////////////////////////////////
  // Program generator and model
  ////////////////////////////////////////
  task automatic build_program();
    logic [31:0] rd, rs1, rs2, k, tgt;
    logic [2:0]  f3;
    for (int i = 0; i < N_INSTR; i++) begin
      rd  = 1 + rand_bits(3) % 7; // x1..x7
      rs1 = 1 + rand_bits(3) % 7;
      rs2 = 1 + rand_bits(3) % 7;
      case (rand_bits(3))
        0: begin
          k = rand_bits(20); // U immediate
          prog[i] = {k[19:0], rd[4:0], OPC_LUI};
        end
        1, 7: begin
          k = rand_bits(3);
          case (k)
            0, 1: f3 = 3'b000;    // ADD, SUB
            2: f3 = 3'b111;
            3: f3 = 3'b110;
            4: f3 = 3'b100;
            5: f3 = 3'b010;
            6: f3 = 3'b001;
            default: f3 = 3'b101;
          endcase
          prog[i] = enc_r((k == 1) ? 7'h20 : 7'h00, rs2, rs1, f3, rd, OPC_OP);
        end
        2: begin
          k = rand_bits(3) % 5;
          f3 = (k == 0) ? 3'b000 : (k == 1) ? 3'b111 : (k == 2) ? 3'b110 :
               (k == 3) ? 3'b100 : 3'b010;
          prog[i] = enc_i(rand_bits(12), rs1, f3, rd, OPC_OP_IMM);
        end
        3: prog[i] = enc_i(rand_bits(6) << 2, 0, 3'b010, rd, OPC_LOAD);
        4, 5: prog[i] = enc_s(rand_bits(6) << 2, rs2);
        default: begin
          tgt = i + 1 + rand_bits(2); // Forward only
          if (tgt > N_INSTR) tgt = N_INSTR;
          f3 = rand_bits(1) ? 3'b001 : 3'b000;
          prog[i] = enc_b((tgt - i) * 4, rs2, rs1, f3);
        end
      endcase
    end
    for (int i = 0; i < 64; i++) begin
      dmem[i]      = rand_bits(32);
      model_mem[i] = dmem[i];
    end
  endtask

  task automatic run_model();
    word_t x [0:31];
    word_t pc, ins, a, b, nxt, addr;
    int    steps;
    for (int i = 0; i < 32; i++) x[i] = '0;
    pc    = BOOT;
    steps = 0;
    while (pc != END_ADDR && steps < 1000) begin
      pc_trace.push_back(pc);
      ins = prog[(pc - BOOT) >> 2];
      a   = x[ins[19:15]];
      b   = x[ins[24:20]];
      nxt = pc + 4;
      case (ins[6:0])
        OPC_LUI:    x[ins[11:7]] = {ins[31:12], 12'd0};
        OPC_OP:     x[ins[11:7]] = alu_ref(ins[14:12], ins[30], a, b);
        OPC_OP_IMM: x[ins[11:7]] = alu_ref(ins[14:12], 1'b0, a, {{20{ins[31]}}, ins[31:20]});
        OPC_LOAD: begin
          addr = a + {{20{ins[31]}}, ins[31:20]};
          x[ins[11:7]] = model_mem[addr[7:2]];
        end
        OPC_STORE: begin
          addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
          st_addr.push_back(addr);
          st_data.push_back(b);
          model_mem[addr[7:2]] = b;
        end
        OPC_BRANCH: begin
          if ((ins[14:12] == 3'b000) == (a == b)) begin // BEQ equal or BNE differ
            nxt = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
          end
        end
        default: ;
      endcase
      x[0]  = '0;
      pc    = nxt;
      steps = steps + 1;
    end
    pc_trace.push_back(END_ADDR); // End word is fetched too
  endtask

  ////////////////////////////////////////
  // Memory models
  ////////////////////////////////////////
  always begin : instr_mem_model
    word_t a;
    int    d;
    @(negedge clk);
    if (rst_n_i && instr_req_o) begin
      a = instr_addr_o;
      d = rand_bits(2);
      repeat (d) begin
        @(negedge clk);
        assert (instr_req_o && instr_addr_o == a) else begin
          $display("[FAIL] %0t ns: instr request moved before grant", $time);
          err[3]++;
        end
      end
      assert (fetch_idx < pc_trace.size() && a == pc_trace[fetch_idx]) else begin
        $display("[FAIL] %0t ns: fetch %0d at %h, model differs", $time, fetch_idx, a);
        err[1]++;
      end
      fetch_idx++;
      instr_gnt_i = 1'b1;
      @(negedge clk);
      instr_gnt_i = 1'b0;
      d = rand_bits(2);
      repeat (d) begin
        assert (!instr_req_o) else begin
          $display("[FAIL] %0t ns: instr request before rvalid", $time);
          err[3]++;
        end
        @(negedge clk);
      end
      instr_rvalid_i = 1'b1;
      instr_rdata_i  = (a >= BOOT && a < END_ADDR) ? prog[(a - BOOT) >> 2] : NOP;
      @(negedge clk);
      instr_rvalid_i = 1'b0;
    end
  end

  always begin : data_mem_model
    word_t a, w;
    logic  we;
    int    d;
    @(negedge clk);
    if (rst_n_i && data_req_o) begin
      a  = data_addr_o;
      w  = data_wdata_o;
      we = data_we_o;
      d  = rand_bits(2);
      repeat (d) begin
        @(negedge clk);
        assert (data_req_o && data_addr_o == a && data_we_o == we && data_wdata_o == w)
        else begin
          $display("[FAIL] %0t ns: data request moved before grant", $time);
          err[3]++;
        end
      end
      if (we) begin
        assert (st_idx < st_addr.size() && a == st_addr[st_idx] && w == st_data[st_idx])
        else begin
          $display("[FAIL] %0t ns: store %0d wrote %h to %h, model differs",
                   $time, st_idx, w, a);
          err[2]++;
        end
        st_idx++;
        dmem[a[7:2]] = w;
      end
      data_gnt_i = 1'b1;
      @(negedge clk);
      data_gnt_i = 1'b0;
      d = rand_bits(2);
      repeat (d) begin
        assert (!data_req_o) else begin
          $display("[FAIL] %0t ns: data request before rvalid", $time);
          err[3]++;
        end
        @(negedge clk);
      end
      data_rvalid_i = 1'b1;
      data_rdata_i  = dmem[a[7:2]]; // Load data, don't care on stores
      @(negedge clk);
      data_rvalid_i = 1'b0;
    end
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////
  initial begin
    $timeformat(-9, 0, "", 0);
    clk = 1'b0;
    rst_n_i = 1'b0;
    boot_addr_i = BOOT;
    fetch_enable_i = 1'b0;
    instr_gnt_i = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i = '0;
    data_gnt_i = 1'b0;
    data_rvalid_i = 1'b0;
    data_rdata_i = '0;
    lfsr_state = 32'h0495_5e21;
    fetch_idx = 0;
    st_idx = 0;
    aborted = 1'b0;
    for (int i = 0; i < 5; i++) err[i] = 0;
    build_program();
    run_model();

    // Reset, then idle with fetch disabled
    repeat (20) begin
      @(negedge clk);
      assert (!instr_req_o && !data_req_o && !data_we_o && !core_busy_o) else begin
        $display("[FAIL] %0t ns: activity while idle", $time);
        err[0]++;
      end
      cnt++;
      if (cnt == 16) rst_n_i = 1'b1;
    end
    fetch_enable_i = 1'b1;
    cnt = 0;
    while (!instr_req_o && cnt < 20) begin
      @(negedge clk);
      cnt++;
    end
    if (!instr_req_o) begin
      $display("Timeout: no fetch after fetch enable");
      aborted = 1'b1;
    end else begin
      assert (instr_addr_o == BOOT) else begin
        $display("[FAIL] %0t ns: first fetch %h, expected %h", $time, instr_addr_o, BOOT);
        err[0]++;
      end
    end
    $display("test reset and boot: %0d errors", err[0]);

    // Run to the end word, then stop fetching
    cnt = 0;
    while (!aborted && !(instr_req_o && instr_addr_o == END_ADDR) && cnt < 40000) begin
      @(negedge clk);
      cnt++;
    end
    if (!aborted && !(instr_req_o && instr_addr_o == END_ADDR)) begin
      $display("Timeout: program never reached its end address");
      aborted = 1'b1;
    end
    fetch_enable_i = 1'b0;
    cnt = 0;
    while (!aborted && core_busy_o && cnt < 100) begin
      @(negedge clk);
      cnt++;
    end
    if (!aborted && core_busy_o) begin
      $display("Timeout: core stayed busy after fetch enable dropped");
      aborted = 1'b1;
    end
    if (!aborted) begin
      repeat (50) begin
        @(negedge clk);
        assert (!instr_req_o && !data_req_o && !core_busy_o) else begin
          $display("[FAIL] %0t ns: request after shutdown", $time);
          err[4]++;
        end
      end
    end
    assert (fetch_idx == pc_trace.size()) else begin
      $display("[FAIL] %0t ns: %0d fetches, model has %0d", $time, fetch_idx, pc_trace.size());
      err[1]++;
    end
    assert (st_idx == st_addr.size()) else begin
      $display("[FAIL] %0t ns: %0d stores, model has %0d", $time, st_idx, st_addr.size());
      err[2]++;
    end
    $display("test fetch trace: %0d errors", err[1]);
    $display("test store trace: %0d errors", err[2]);
    $display("test handshake: %0d errors", err[3]);
    $display("test shutdown: %0d errors", err[4]);
    total = err[0] + err[1] + err[2] + err[3] + err[4];
    $display("summary: 5 tests, %0d fetches, %0d stores, %0d errors", fetch_idx, st_idx, total);
    if (total == 0 && !aborted) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
